// File: board_top.sv
`default_nettype none

module board_top
  import code_mem_pkg::*, io_map_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 resetq,
  input  wire logic                 wb_cyc,
  input  wire logic                 wb_stb,
  input  wire logic                 wb_we,
  input  wire logic [BUS_ADR_W-1:0] wb_adr,
  input  wire code_word_t           wb_dat_w,
  output logic                      wb_ack,
  output code_word_t                wb_dat_r,
  // instruction fetch
  input  wire code_addr_t           code_addr,
  output code_word_t                insn,
  output logic [LED_W-1:0]          leds,
  output logic                      tx,
  input  wire logic                 rx
);

  logic                  mem_we;
  logic [CODE_ROW_W-1:0] mem_row;
  logic                  mem_bank;
  code_word_t            mem_data;
  logic                  tx_start;
  uart_byte_t            tx_byte;
  logic                  tx_busy;
  uart_byte_t            rx_byte;
  logic                  rx_valid;
  logic                  rx_take;

  io_bus_ctrl u_ctrl (
    .clk      (clk),
    .resetq   (resetq),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_ack   (wb_ack),
    .wb_dat_r (wb_dat_r),
    .mem_we   (mem_we),
    .mem_row  (mem_row),
    .mem_bank (mem_bank),
    .mem_data (mem_data),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_busy  (tx_busy),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .rx_take  (rx_take),
    .leds     (leds)
  );

  code_ram u_code (
    .clk       (clk),
    .mem_we    (mem_we),
    .mem_row   (mem_row),
    .mem_bank  (mem_bank),
    .mem_data  (mem_data),
    .code_addr (code_addr),
    .insn      (insn)
  );

  uart_tx u_tx (
    .clk      (clk),
    .resetq   (resetq),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_busy  (tx_busy)
  );

  uart_rx u_rx (
    .clk      (clk),
    .resetq   (resetq),
    .rx       (rx),
    .rx_take  (rx_take),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

endmodule

`default_nettype wire

// File: build.f
code_mem_pkg.sv
io_map_pkg.sv
code_ram.sv
uart_tx.sv
uart_rx.sv
io_bus_ctrl.sv
board_top.sv
tb_board.sv

// File: code_mem_pkg.sv
`default_nettype none

package code_mem_pkg;

  // instruction and data word
  localparam int CODE_W = 16;

  // one bank holds 2**CODE_ROW_W words
  localparam int CODE_ROW_W = 11;
  localparam int CODE_BANKS = 2;
  localparam int CODE_DEPTH = 1 << CODE_ROW_W;

  // fetch address is row plus bank select on top
  localparam int CODE_ADDR_W = CODE_ROW_W + $clog2(CODE_BANKS);

  typedef logic [CODE_W-1:0] code_word_t;
  typedef logic [CODE_ADDR_W-1:0] code_addr_t;

endpackage

`default_nettype wire

// File: code_ram.sv
`default_nettype none

module code_ram
  import code_mem_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  mem_we,
  input  wire logic [CODE_ROW_W-1:0] mem_row,
  input  wire logic                  mem_bank,
  input  wire code_word_t            mem_data,
  input  wire code_addr_t            code_addr,
  output code_word_t                 insn
);

  // registered read data of each bank
  code_word_t rd_data [CODE_BANKS];

  // bank select travels with the read
  logic [$clog2(CODE_BANKS)-1:0] bank_q;

  for (genvar b = 0; b < CODE_BANKS; b++) begin : g_bank
    code_word_t bank_mem [CODE_DEPTH];

    // program image is empty at power up
    initial begin
      for (int r = 0; r < CODE_DEPTH; r++) begin
        bank_mem[r] = '0;
      end
    end

    // bus side write port
    always_ff @(posedge clk) begin
      if (mem_we && (mem_bank == 1'(b))) begin
        bank_mem[mem_row] <= mem_data;
      end
    end

    // fetch side read port
    always_ff @(posedge clk) begin
      rd_data[b] <= bank_mem[code_addr[CODE_ROW_W-1:0]];
    end
  end

  always_ff @(posedge clk) begin
    bank_q <= code_addr[CODE_ADDR_W-1:CODE_ROW_W];
  end

  // pick the bank that was addressed at the sampling edge
  assign insn = rd_data[bank_q];

  // an X bank bit would corrupt both banks at once
  bank_known: assert property (@(posedge clk)
    mem_we |-> !$isunknown(mem_bank));

endmodule

`default_nettype wire

// File: io_bus_ctrl.sv
`default_nettype none

module io_bus_ctrl
  import code_mem_pkg::*, io_map_pkg::*;
(
  input  wire logic                 clk,
  input  wire logic                 resetq,
  // wishbone classic slave
  input  wire logic                 wb_cyc,
  input  wire logic                 wb_stb,
  input  wire logic                 wb_we,
  input  wire logic [BUS_ADR_W-1:0] wb_adr,
  input  wire code_word_t           wb_dat_w,
  output logic                      wb_ack,
  output code_word_t                wb_dat_r,
  // code memory write port
  output logic                      mem_we,
  output logic [CODE_ROW_W-1:0]     mem_row,
  output logic                      mem_bank,
  output code_word_t                mem_data,
  // uart
  output logic                      tx_start,
  output uart_byte_t                tx_byte,
  input  wire logic                 tx_busy,
  input  wire uart_byte_t           rx_byte,
  input  wire logic                 rx_valid,
  output logic                      rx_take,
  output logic [LED_W-1:0]          leds
);

  logic                 req;
  // I/O stage holds the request during the ack cycle
  logic                 wr_q;
  logic                 rd_q;
  logic [BUS_ADR_W-1:0] adr_q;
  code_word_t           dat_q;

  logic       io_wr;
  logic       io_rd;
  logic       unlocked;
  code_word_t status_word;

  // new request only while ack is low
  assign req = wb_cyc && wb_stb && !wb_ack;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      wb_ack <= 1'b0;
      wr_q   <= 1'b0;
      rd_q   <= 1'b0;
    end else begin
      wb_ack <= req;
      wr_q   <= req && wb_we;
      rd_q   <= req && !wb_we;
    end
  end

  always_ff @(posedge clk) begin
    if (req) begin
      adr_q <= wb_adr;
      dat_q <= wb_dat_w;
    end
  end

  assign io_wr = wr_q && adr_q[IO_SPACE_BIT];
  assign io_rd = rd_q && adr_q[IO_SPACE_BIT];

  // code memory stays read-only until software touches I/O once
  always_ff @(posedge clk) begin
    if (!resetq) begin
      unlocked <= 1'b0;
    end else if (io_wr) begin
      unlocked <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetq) begin
      leds <= '0;
    end else if (io_wr && adr_q[IO_LEDS_BIT]) begin
      leds <= dat_q[LED_W-1:0];
    end
  end

  assign mem_we   = wr_q && !adr_q[IO_SPACE_BIT] && unlocked;
  assign mem_row  = adr_q[MEM_ROW_LSB +: CODE_ROW_W];
  assign mem_bank = adr_q[MEM_BANK_BIT];
  assign mem_data = dat_q;

  assign tx_start = io_wr && adr_q[IO_UART_BIT];
  assign tx_byte  = dat_q[7:0];
  // reading the data register consumes the byte
  assign rx_take  = io_rd && adr_q[IO_UART_BIT];

  always_comb begin
    status_word                = '0;
    status_word[ST_TX_READY]   = !tx_busy;
    status_word[ST_RX_VALID]   = rx_valid;
    status_word[ST_ONES +: 2]  = 2'b11;
    status_word[ST_RANDOM]     = 1'b0;
  end

  // or of every selected source
  // memory space reads zero
  assign wb_dat_r =
    ((io_rd && adr_q[IO_LEDS_BIT])   ? code_word_t'(leds)    : '0) |
    ((io_rd && adr_q[IO_UART_BIT])   ? code_word_t'(rx_byte) : '0) |
    ((io_rd && adr_q[IO_STATUS_BIT]) ? status_word           : '0);

  // ack only while the master still holds the strobe
  ack_after_stb: assert property (@(posedge clk) disable iff (!resetq)
    wb_ack |-> wb_cyc && wb_stb);

  // the lock opens only for accesses after the unlocking write
  we_unlocked: assert property (@(posedge clk) disable iff (!resetq)
    mem_we |-> $past(unlocked));

endmodule

`default_nettype wire

// File: io_map_pkg.sv
`default_nettype none

package io_map_pkg;

  // bus byte address, bit 15 splits I/O from code memory
  localparam int BUS_ADR_W = 16;
  localparam int IO_SPACE_BIT = 15;

  // memory space: row from bits 11:1, bank from bit 12
  localparam int MEM_ROW_LSB = 1;
  localparam int MEM_BANK_BIT = 12;

  // one-hot I/O selects
  localparam int IO_LEDS_BIT = 2;
  localparam int IO_UART_BIT = 12;
  localparam int IO_STATUS_BIT = 13;

  localparam int LED_W = 5;

  // status register bits
  localparam int ST_TX_READY = 0;
  localparam int ST_RX_VALID = 1;
  // two bits, 3:2, tied high
  localparam int ST_ONES = 2;
  localparam int ST_RANDOM = 4;

  // 8N1 timing
  localparam int UART_CLKS_PER_BIT = 16;
  localparam int UART_CNT_W = $clog2(UART_CLKS_PER_BIT);
  localparam int UART_FRAME_BITS = 10;

  typedef logic [7:0] uart_byte_t;

endpackage

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_board -f build.f --Mdir obj_dir -o tb_board_sim

output=$(./obj_dir/tb_board_sim)
echo "$output"

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
exit 1

// File: tb_board.sv
`default_nettype none

module tb_board
  import code_mem_pkg::*, io_map_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  logic                 clk;
  logic                 resetq;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  logic [BUS_ADR_W-1:0] wb_adr;
  code_word_t           wb_dat_w;
  logic                 wb_ack;
  code_word_t           wb_dat_r;
  code_addr_t           code_addr;
  code_word_t           insn;
  logic [LED_W-1:0]     leds;
  logic                 tx;
  logic                 rx;

  // reference model of the board
  logic [31:0]      lcg_state;
  code_word_t       shadow [1 << CODE_ADDR_W];
  logic             unlocked_model;
  logic [LED_W-1:0] leds_model;
  code_addr_t       written [$];

  // armed checks
  logic       rd_armed;
  code_word_t rd_exp;
  code_word_t rd_mask;
  logic       fetch_armed;
  code_word_t fetch_exp;
  logic       fetch_armed_q;
  code_word_t fetch_exp_q;
  logic       frame_armed;
  logic [9:0] frame_got;
  logic [9:0] frame_exp;
  logic       tx_quiet;
  logic       tx_done;

  int bus_errors;
  int fetch_errors;
  int io_errors;
  int uart_errors;
  int timeouts;

  board_top DUT (
    .clk       (clk),
    .resetq    (resetq),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .code_addr (code_addr),
    .insn      (insn),
    .leds      (leds),
    .tx        (tx),
    .rx        (rx)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // insn is due one cycle after the address edge
  always @(posedge clk) begin
    fetch_armed_q <= fetch_armed;
    fetch_exp_q   <= fetch_exp;
  end

  reset_state: assert property (@(posedge clk)
    $rose(resetq) |-> {wb_ack, tx, DUT.u_rx.rx_valid} == 3'b010)
    else begin
      io_errors++;
      $display("error wb_ack/tx/rx_valid after reset: got %h expected %h",
        $sampled({wb_ack, tx, DUT.u_rx.rx_valid}), 3'b010);
    end

  leds_value: assert property (@(posedge clk) disable iff (!resetq)
    leds == leds_model)
    else begin
      io_errors++;
      $display("error leds: got %h expected %h", $sampled(leds), $sampled(leds_model));
    end

  read_data: assert property (@(posedge clk) disable iff (!resetq)
    wb_ack && rd_armed |-> (wb_dat_r & rd_mask) == (rd_exp & rd_mask))
    else begin
      bus_errors++;
      $display("error wb_dat_r: got %h expected %h mask %h",
        $sampled(wb_dat_r), $sampled(rd_exp), $sampled(rd_mask));
    end

  fetch_data: assert property (@(posedge clk) disable iff (!resetq)
    fetch_armed_q |-> insn == fetch_exp_q)
    else begin
      fetch_errors++;
      $display("error insn: got %h expected %h", $sampled(insn), $sampled(fetch_exp_q));
    end

  tx_idle: assert property (@(posedge clk) disable iff (!resetq)
    tx_quiet |-> tx)
    else begin
      uart_errors++;
      $display("error tx: got %h expected %h", $sampled(tx), 1'b1);
    end

  tx_frame: assert property (@(posedge clk) disable iff (!resetq)
    frame_armed |-> frame_got == frame_exp)
    else begin
      uart_errors++;
      $display("error tx frame: got %h expected %h", $sampled(frame_got), $sampled(frame_exp));
    end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [BUS_ADR_W-1:0] io_adr(input int sel_bit);
    logic [BUS_ADR_W-1:0] a;
    a               = '0;
    a[IO_SPACE_BIT] = 1'b1;
    a[sel_bit]      = 1'b1;
    return a;
  endfunction

  function automatic logic [BUS_ADR_W-1:0] mem_adr(input code_addr_t fa);
    logic [BUS_ADR_W-1:0] a;
    a                             = '0;
    a[MEM_BANK_BIT]               = fa[CODE_ROW_W];
    a[MEM_ROW_LSB +: CODE_ROW_W]  = fa[CODE_ROW_W-1:0];
    return a;
  endfunction

  function automatic code_word_t status_expect(input logic tx_ready, input logic rx_valid);
    code_word_t s;
    s                = '0;
    s[ST_TX_READY]   = tx_ready;
    s[ST_RX_VALID]   = rx_valid;
    s[ST_ONES]       = 1'b1;
    s[ST_ONES + 1]   = 1'b1;
    return s;
  endfunction

  task automatic step_cycle();
    @(posedge clk);
    #5;
  endtask

  task automatic wait_ack(input logic [BUS_ADR_W-1:0] adr);
    int n;
    n = 0;
    step_cycle();
    while (!wb_ack && n < 20) begin
      step_cycle();
      n++;
    end
    if (!wb_ack) begin
      timeouts++;
      $display("timeout: no ack for the access to %h", adr);
    end
  endtask

  task automatic wb_write(input logic [BUS_ADR_W-1:0] adr, input code_word_t dat);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b1;
    wb_adr   = adr;
    wb_dat_w = dat;
    wait_ack(adr);
    step_cycle();
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    // the write took effect at the edge that ended ack
    if (adr[IO_SPACE_BIT]) begin
      unlocked_model = 1'b1;
      if (adr[IO_LEDS_BIT]) begin
        leds_model = dat[LED_W-1:0];
      end
    end else if (unlocked_model) begin
      shadow[{adr[MEM_BANK_BIT], adr[MEM_ROW_LSB +: CODE_ROW_W]}] = dat;
    end
  endtask

  task automatic wb_read(input logic [BUS_ADR_W-1:0] adr, input code_word_t exp,
                         input code_word_t mask, output code_word_t dat);
    rd_exp   = exp;
    rd_mask  = mask;
    rd_armed = 1'b1;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = 1'b0;
    wb_adr   = adr;
    wait_ack(adr);
    dat = wb_dat_r;
    step_cycle();
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    rd_armed = 1'b0;
  endtask

  task automatic fetch_check(input code_addr_t fa);
    code_addr   = fa;
    fetch_exp   = shadow[fa];
    fetch_armed = 1'b1;
    step_cycle();
  endtask

  // samples each bit in its middle, start bit in bits[0]
  task automatic tx_monitor(output logic [9:0] bits);
    int n;
    n    = 0;
    bits = '1;
    while (tx && n < 40) begin
      step_cycle();
      n++;
    end
    if (tx) begin
      timeouts++;
      $display("timeout: no start bit on tx");
    end else begin
      repeat (UART_CLKS_PER_BIT / 2) step_cycle();
      for (int i = 0; i < 10; i++) begin
        bits[i] = tx;
        if (i < 9) begin
          repeat (UART_CLKS_PER_BIT) step_cycle();
        end
      end
    end
  endtask

  task automatic rx_send(input uart_byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rx = frame[i];
      repeat (UART_CLKS_PER_BIT) step_cycle();
    end
  endtask

  initial begin
    code_word_t  dat;
    code_word_t  word;
    logic [31:0] r;
    logic [9:0]  got;
    code_addr_t  fa;
    code_addr_t  locked_addr;
    uart_byte_t  rx_b;
    int          n;
    int          polls;

    resetq      = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    code_addr   = '0;
    rx          = 1'b1;
    lcg_state   = 32'h19e;
    rd_armed    = 1'b0;
    rd_exp      = '0;
    rd_mask     = '0;
    fetch_armed = 1'b0;
    fetch_exp   = '0;
    frame_armed = 1'b0;
    frame_got   = '0;
    frame_exp   = '0;
    tx_quiet    = 1'b0;
    tx_done     = 1'b0;
    unlocked_model = 1'b0;
    leds_model     = '0;
    for (int a = 0; a < (1 << CODE_ADDR_W); a++) begin
      shadow[a] = '0;
    end

    repeat (10) @(posedge clk);
    #5;
    resetq   = 1'b1;
    tx_quiet = 1'b1;
    step_cycle();

    // idle status, memory space reads zero
    wb_read(io_adr(IO_STATUS_BIT), status_expect(1'b1, 1'b0), '1, dat);
    wb_read(mem_adr(12'h005), '0, '1, dat);

    // still locked, this write must not land
    r = lcg_next();
    locked_addr = r[27:16];
    r = lcg_next();
    wb_write(mem_adr(locked_addr), r[31:16]);
    fetch_check(locked_addr);
    fetch_armed = 1'b0;
    step_cycle();

    // first I/O write also unlocks code memory
    r = lcg_next();
    wb_write(io_adr(IO_LEDS_BIT), r[31:16]);
    wb_read(io_adr(IO_LEDS_BIT), code_word_t'(leds_model), '1, dat);

    for (int i = 0; i < 16; i++) begin
      r  = lcg_next();
      fa = {i[0], r[26:16]};
      r  = lcg_next();
      word = r[31:16];
      wb_write(mem_adr(fa), word);
      written.push_back(fa);
    end
    written.push_back(locked_addr);
    foreach (written[k]) begin
      fetch_check(written[k]);
    end
    fetch_armed = 1'b0;
    step_cycle();
    step_cycle();

    // one transmit frame, status busy while it runs
    r = lcg_next();
    word     = code_word_t'(r[23:16]);
    tx_quiet = 1'b0;
    fork
      begin
        tx_monitor(got);
        tx_done = 1'b1;
      end
      begin
        wb_write(io_adr(IO_UART_BIT), word);
        polls = 0;
        while (!tx_done && polls < 200) begin
          wb_read(io_adr(IO_STATUS_BIT), status_expect(1'b0, 1'b0),
                  status_expect(1'b1, 1'b0), dat);
          polls++;
        end
      end
    join
    frame_got   = got;
    frame_exp   = {1'b1, word[7:0], 1'b0};
    frame_armed = 1'b1;
    tx_quiet    = 1'b1;
    step_cycle();
    frame_armed = 1'b0;

    n   = 0;
    dat = '0;
    while (!dat[ST_TX_READY] && n < 20) begin
      wb_read(io_adr(IO_STATUS_BIT), '0, '0, dat);
      n++;
    end
    if (!dat[ST_TX_READY]) begin
      timeouts++;
      $display("timeout: transmitter never became ready again");
    end
    wb_read(io_adr(IO_STATUS_BIT), status_expect(1'b1, 1'b0), '1, dat);

    // receive one byte, reading it clears the valid bit
    r    = lcg_next();
    rx_b = r[31:24];
    rx_send(rx_b);
    n   = 0;
    dat = '0;
    while (!dat[ST_RX_VALID] && n < 20) begin
      wb_read(io_adr(IO_STATUS_BIT), '0, '0, dat);
      n++;
    end
    if (!dat[ST_RX_VALID]) begin
      timeouts++;
      $display("timeout: received byte never became valid");
    end
    wb_read(io_adr(IO_STATUS_BIT), status_expect(1'b1, 1'b1), '1, dat);
    wb_read(io_adr(IO_UART_BIT), code_word_t'(rx_b), '1, dat);
    wb_read(io_adr(IO_STATUS_BIT), status_expect(1'b1, 1'b0), '1, dat);
    step_cycle();

    $display("errors: bus %0d, fetch %0d, io %0d, uart %0d, timeouts %0d",
      bus_errors, fetch_errors, io_errors, uart_errors, timeouts);
    if (bus_errors + fetch_errors + io_errors + uart_errors + timeouts == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: uart_rx.sv
`default_nettype none

module uart_rx
  import io_map_pkg::*;
(
  input  wire logic clk,
  input  wire logic resetq,
  input  wire logic rx,
  input  wire logic rx_take,
  output uart_byte_t rx_byte,
  output logic       rx_valid
);

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP,
    RX_DONE
  } rx_state_t;

  rx_state_t             state;
  logic                  rx_s1;
  logic                  rx_s2;
  logic [UART_CNT_W-1:0] clk_cnt;
  logic [2:0]            bit_idx;
  uart_byte_t            shreg;
  logic                  stop_ok;

  // two flop synchronizer, idles high
  always_ff @(posedge clk) begin
    if (!resetq) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetq) begin
      state    <= RX_IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      stop_ok  <= 1'b0;
      rx_valid <= 1'b0;
    end else begin
      if (rx_take) begin
        rx_valid <= 1'b0;
      end
      if (state != RX_IDLE && clk_cnt != '0) begin
        clk_cnt <= clk_cnt - 1'b1;
      end else begin
        case (state)
          RX_IDLE: begin
            // falling edge, wait half a bit to reach mid start
            if (!rx_s2) begin
              state   <= RX_START;
              clk_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1);
            end
          end
          RX_START: begin
            // glitch if the line is back high
            state   <= rx_s2 ? RX_IDLE : RX_DATA;
            clk_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT - 1);
            bit_idx <= '0;
          end
          RX_DATA: begin
            clk_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT - 1);
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
          RX_STOP: begin
            stop_ok <= rx_s2;
            state   <= RX_DONE;
            clk_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT / 2 - 1);
          end
          default: begin
            // end of stop bit
            if (stop_ok) begin
              rx_valid <= 1'b1;
            end
            state <= RX_IDLE;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == RX_DATA && clk_cnt == '0) begin
      shreg <= {rx_s2, shreg[7:1]};
    end
    if (state == RX_DONE && clk_cnt == '0 && stop_ok) begin
      rx_byte <= shreg;
    end
  end

endmodule

`default_nettype wire

// File: uart_tx.sv
`default_nettype none

module uart_tx
  import io_map_pkg::*;
(
  input  wire logic       clk,
  input  wire logic       resetq,
  input  wire logic       tx_start,
  input  wire uart_byte_t tx_byte,
  output logic            tx,
  output logic            tx_busy
);

  // data bits then stop bit, shifted out lsb first
  logic [8:0]            frame;
  logic [3:0]            bits_left;
  logic [UART_CNT_W-1:0] clk_cnt;

  always_ff @(posedge clk) begin
    if (!resetq) begin
      tx        <= 1'b1;
      tx_busy   <= 1'b0;
      bits_left <= '0;
      clk_cnt   <= '0;
    end else if (!tx_busy) begin
      // a start while busy is simply ignored
      if (tx_start) begin
        tx        <= 1'b0;
        tx_busy   <= 1'b1;
        bits_left <= 4'(UART_FRAME_BITS - 1);
        clk_cnt   <= UART_CNT_W'(UART_CLKS_PER_BIT - 1);
      end
    end else if (clk_cnt != '0) begin
      clk_cnt <= clk_cnt - 1'b1;
    end else begin
      clk_cnt <= UART_CNT_W'(UART_CLKS_PER_BIT - 1);
      if (bits_left == '0) begin
        // stop bit done, line stays high
        tx_busy <= 1'b0;
      end else begin
        tx        <= frame[0];
        bits_left <= bits_left - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tx_start && !tx_busy) begin
      frame <= {1'b1, tx_byte};
    end else if (tx_busy && clk_cnt == '0 && bits_left != '0) begin
      frame <= {1'b1, frame[8:1]};
    end
  end

  // an accepted frame runs its full length and is never restarted
  frame_len: assert property (@(posedge clk) disable iff (!resetq)
    tx_start && !tx_busy |=>
      tx_busy [* UART_FRAME_BITS * UART_CLKS_PER_BIT] ##1 !tx_busy);

endmodule

`default_nettype wire
